/* rtl/ctr_pkg.sv */
// Shared widths and control bundles for the counter board; all widths fixed, one clock domain
`default_nettype none

package ctr_pkg;

   //////////////////////////////////////////////////
   // Widths with a meaning
   //////////////////////////////////////////////////

   typedef logic [3:0]  nibble_t;   // One chip slice
   typedef logic [15:0] word16_t;   // Interval timer value
   typedef logic [7:0]  byte_t;     // Position and event counts
   typedef logic [9:0]  phase_t;    // One-hot decade phase

   localparam nibble_t NIBBLE_MAX   = 4'hF;  // Slice terminal count going up
   localparam int      DECADE_LEN   = 10;    // Phases per decade cycle
   localparam int      DECADE_HALF  = 5;     // Phases with carry high
   localparam int      TIMER_SLICES = 4;     // 161 slices in the 16-bit timer

   //////////////////////////////////////////////////
   // Control bundles from the host
   //////////////////////////////////////////////////

   typedef struct packed {
      logic    load;    // Strobe, take reload value
      logic    run;     // Level, count enable
      word16_t reload;  // Period reload value
   } timer_ctl_t;

   typedef struct packed {
      logic  preset;  // Strobe, parallel load
      logic  step;    // Strobe, count one
      logic  down;    // Level, direction
      byte_t value;   // Preset value
   } pos_ctl_t;

   typedef struct packed {
      logic event_in;  // Strobe, count one event
      logic clear;     // Strobe, zero the count
      logic snap;      // Strobe, copy count to output register
   } evt_ctl_t;

endpackage

`default_nettype wire

/* rtl/counter_161.sv */
// Synchronous 74x161 slice; load and clear sampled on clk, no async pins
`timescale 1ns/1ps
`default_nettype none

module counter_161 (
   input  wire              clk,
   input  wire              reset,
   input  wire              load,     // Parallel load, wins over counting
   input  wire              cet,      // Carry enable in, also gates tc
   input  wire              cep,      // Count enable, not in tc
   input  wire ctr_pkg::nibble_t preset,
   output ctr_pkg::nibble_t q,
   output logic             tc
);

   //////////////////////////////////////////////////
   // Count register
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         q <= '0;
      end else if (load) begin
         q <= preset;              // Preset wins
      end else if (cet && cep) begin
         q <= q + 4'd1;            // Wraps 15 to 0
      end
   end

   // Terminal count ripples the enable to the next slice
   // Only cet qualifies it, as on the real chip
   assign tc = cet && (q == ctr_pkg::NIBBLE_MAX);

endmodule

`default_nettype wire

/* rtl/interval_timer.sv */
// 16-bit auto-reloading timer; tick period is 65536 minus reload while run stays high
`timescale 1ns/1ps
`default_nettype none

module interval_timer (
   input  wire                     clk,
   input  wire                     reset,
   input  wire ctr_pkg::timer_ctl_t ctl,
   output wire ctr_pkg::word16_t   count,
   output wire                     tick
);

   logic [ctr_pkg::TIMER_SLICES:0] carry;     // Enable chain from slice to slice
   ctr_pkg::word16_t               reload_q;  // Stored reload value
   ctr_pkg::word16_t               preset;    // Value the slices load
   logic                           load_all;  // Shared slice load

   //////////////////////////////////////////////////
   // Reload register
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         reload_q <= '0;
      end else if (ctl.load) begin
         reload_q <= ctl.reload;
      end
   end

   // Host load bypasses the register so the slices see the new value now
   assign preset   = ctl.load ? ctl.reload : reload_q;
   assign load_all = ctl.load | tick;      // Self reload from terminal count
   assign carry[0] = ctl.run;              // Lowest slice enabled by run

   //////////////////////////////////////////////////
   // Slice cascade, low nibble first
   //////////////////////////////////////////////////

   for (genvar i = 0; i < ctr_pkg::TIMER_SLICES; i++) begin : g_slice
      counter_161 u_slice (
         .clk    (clk),
         .reset  (reset),
         .load   (load_all),
         .cet    (carry[i]),           // Previous slice tc
         .cep    (ctl.run),
         .preset (preset[4*i +: 4]),
         .q      (count[4*i +: 4]),
         .tc     (carry[i+1])
      );
   end

   // Top tc means all ones with run high
   assign tick = carry[ctr_pkg::TIMER_SLICES];

endmodule

`default_nettype wire

/* rtl/counter_191.sv */
// Synchronous 74x191 slice; preset sampled on clk, ripple clock output not modelled
`timescale 1ns/1ps
`default_nettype none

module counter_191 (
   input  wire              clk,
   input  wire              reset,
   input  wire              load,     // Parallel load, wins over enable
   input  wire              enable,   // Count enable, active high here
   input  wire              down,     // 0 up, 1 down
   input  wire ctr_pkg::nibble_t preset,
   output ctr_pkg::nibble_t q,
   output logic             tc
);

   //////////////////////////////////////////////////
   // Up/down count register
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         q <= '0;
      end else if (load) begin
         q <= preset;
      end else if (enable) begin
         if (down) begin
            q <= q - 4'd1;         // 0 wraps to 15
         end else begin
            q <= q + 4'd1;         // 15 wraps to 0
         end
      end
   end

   // Terminal value depends on direction only
   // Not qualified by enable, same as the chip's TC pin
   always_comb begin
      if (down) begin
         tc = (q == '0);
      end else begin
         tc = (q == ctr_pkg::NIBBLE_MAX);
      end
   end

endmodule

`default_nettype wire

/* rtl/updown_counter.sv */
// 8-bit position counter from two 191 slices; step and preset are single-cycle strobes
`timescale 1ns/1ps
`default_nettype none

module updown_counter (
   input  wire                   clk,
   input  wire                   reset,
   input  wire ctr_pkg::pos_ctl_t ctl,
   output wire ctr_pkg::byte_t   position,
   output wire                   terminal
);

   logic tc_lo;      // Low slice at its terminal value
   logic tc_hi;      // High slice at its terminal value
   logic enable_hi;  // Carry or borrow into the high slice

   //////////////////////////////////////////////////
   // Low nibble
   //////////////////////////////////////////////////

   counter_191 u_low (
      .clk    (clk),
      .reset  (reset),
      .load   (ctl.preset),
      .enable (ctl.step),
      .down   (ctl.down),
      .preset (ctl.value[3:0]),
      .q      (position[3:0]),
      .tc     (tc_lo)
   );

   // Ripple role of the 191, high slice moves only on low wrap
   assign enable_hi = ctl.step & tc_lo;

   //////////////////////////////////////////////////
   // High nibble
   //////////////////////////////////////////////////

   counter_191 u_high (
      .clk    (clk),
      .reset  (reset),
      .load   (ctl.preset),        // Both nibbles preset together
      .enable (enable_hi),
      .down   (ctl.down),
      .preset (ctl.value[7:4]),
      .q      (position[7:4]),
      .tc     (tc_hi)
   );

   // 255 going up or 0 going down
   assign terminal = tc_hi & tc_lo;

endmodule

`default_nettype wire

/* rtl/event_counter.sv */
// 590-style event counter; output register always enabled, no tri-state output
`timescale 1ns/1ps
`default_nettype none

module event_counter (
   input  wire                   clk,
   input  wire                   reset,
   input  wire ctr_pkg::evt_ctl_t ctl,
   output ctr_pkg::byte_t        snapshot,
   output logic                  rco
);

   ctr_pkg::byte_t count;  // Internal counting register

   //////////////////////////////////////////////////
   // Counting register
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (ctl.clear) begin
         count <= '0;              // Clear beats a same-cycle event
      end else if (ctl.event_in) begin
         count <= count + 8'd1;    // Wraps at 255
      end
   end

   //////////////////////////////////////////////////
   // Output register, the rck side
   //////////////////////////////////////////////////

   // Takes the count from before this edge
   always_ff @(posedge clk) begin
      if (reset) begin
         snapshot <= '0;
      end else if (ctl.snap) begin
         snapshot <= count;
      end
   end

   // Ripple carry on the live count, active high here
   assign rco = (count == '1);

endmodule

`default_nettype wire

/* rtl/decade_sequencer.sv */
// 4017-style one-hot divide-by-ten; advance is a one-cycle strobe on clk
`timescale 1ns/1ps
`default_nettype none

module decade_sequencer (
   input  wire            clk,
   input  wire            reset,
   input  wire            advance,   // One step per strobe
   output ctr_pkg::phase_t phase,
   output logic           carry
);

   logic [3:0] step_cnt;  // Decade position 0 to 9

   always_ff @(posedge clk) begin
      if (reset) begin
         step_cnt <= '0;
      end else if (advance) begin
         if (step_cnt == 4'(ctr_pkg::DECADE_LEN - 1)) begin
            step_cnt <= '0;           // Wrap after the tenth phase
         end else begin
            step_cnt <= step_cnt + 4'd1;
         end
      end
   end

   // One-hot decode of the position
   assign phase = ctr_pkg::phase_t'(1) << step_cnt;

   // High for the first half of the decade
   assign carry = (step_cnt < 4'(ctr_pkg::DECADE_HALF));

endmodule

`default_nettype wire

/* rtl/counter_board.sv */
// Counter board top; single clock, synchronous reset, all controls are plain strobes and levels
`timescale 1ns/1ps
`default_nettype none

module counter_board (
   input  wire                      clk,
   input  wire                      reset,
   input  wire ctr_pkg::timer_ctl_t timer_ctl,
   input  wire ctr_pkg::pos_ctl_t   pos_ctl,
   input  wire ctr_pkg::evt_ctl_t   evt_ctl,
   output wire ctr_pkg::word16_t    timer_count,
   output wire                      tick,
   output wire ctr_pkg::phase_t     phase,
   output wire                      decade_carry,
   output wire ctr_pkg::byte_t      position,
   output wire                      position_tc,
   output wire ctr_pkg::byte_t      event_snapshot,
   output wire                      event_rco
);

   //////////////////////////////////////////////////
   // Timer drives the sequencer
   //////////////////////////////////////////////////

   interval_timer u_timer (
      .clk   (clk),
      .reset (reset),
      .ctl   (timer_ctl),
      .count (timer_count),
      .tick  (tick)
   );

   decade_sequencer u_decade (
      .clk     (clk),
      .reset   (reset),
      .advance (tick),          // One phase per timer tick
      .phase   (phase),
      .carry   (decade_carry)
   );

   //////////////////////////////////////////////////
   // Independent counters
   //////////////////////////////////////////////////

   updown_counter u_position (
      .clk      (clk),
      .reset    (reset),
      .ctl      (pos_ctl),
      .position (position),
      .terminal (position_tc)
   );

   event_counter u_event (
      .clk      (clk),
      .reset    (reset),
      .ctl      (evt_ctl),
      .snapshot (event_snapshot),
      .rco      (event_rco)
   );

endmodule

`default_nettype wire

/* bench/board_checker.sv */
// Reference models of the counter board; compares on the falling edge, needs reset before checking
`timescale 1ns/1ps
`default_nettype none

module board_checker (
   input  wire                      clk,
   input  wire                      reset,
   input  wire ctr_pkg::timer_ctl_t timer_ctl,
   input  wire ctr_pkg::pos_ctl_t   pos_ctl,
   input  wire ctr_pkg::evt_ctl_t   evt_ctl,
   input  wire ctr_pkg::word16_t    timer_count,
   input  wire                      tick,
   input  wire ctr_pkg::phase_t     phase,
   input  wire                      decade_carry,
   input  wire ctr_pkg::byte_t      position,
   input  wire                      position_tc,
   input  wire ctr_pkg::byte_t      event_snapshot,
   input  wire                      event_rco,
   output int                       error_count,
   output int                       check_count
);

   ctr_pkg::word16_t m_count  = '0;    // Timer count model
   ctr_pkg::word16_t m_reload = '0;    // Stored reload model
   ctr_pkg::phase_t  m_phase  = 10'd1; // One-hot decade phase model
   ctr_pkg::byte_t   m_pos    = '0;    // Position model
   ctr_pkg::byte_t   m_evt    = '0;    // Event count model
   ctr_pkg::byte_t   m_snap   = '0;    // Snapshot model
   logic             model_valid = 1'b0;  // Set once a reset has been seen
   int               gap       = 0;    // Cycles since last tick
   logic             gap_valid = 1'b0; // Gap measured under steady run
   int               errors    = 0;
   int               checks    = 0;
   logic             exp_tick;
   logic             exp_ptc;

   assign error_count = errors;
   assign check_count = checks;

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("FAILED %0t: %s is %h, expected %h", $time, name, got, expected);
      end
   endtask

   //////////////////////////////////////////////////
   // Compare, then step the models
   //////////////////////////////////////////////////

   always @(negedge clk) begin
      exp_tick = timer_ctl.run && (m_count == 16'hFFFF);       // All ones with run
      exp_ptc  = pos_ctl.down ? (m_pos == 8'h00) : (m_pos == 8'hFF);
      if (model_valid) begin
         check_value("timer_count", timer_count, m_count);
         check_value("tick", 16'(tick), 16'(exp_tick));
         check_value("phase", 16'(phase), 16'(m_phase));
         check_value("decade_carry", 16'(decade_carry), 16'(|m_phase[4:0]));  // Phases 0 to 4
         check_value("position", 16'(position), 16'(m_pos));
         check_value("position_tc", 16'(position_tc), 16'(exp_ptc));
         check_value("event_snapshot", 16'(event_snapshot), 16'(m_snap));
         check_value("event_rco", 16'(event_rco), 16'(m_evt == 8'hFF));
      end

      // Spacing of the DUT's ticks under steady run
      if (!reset && model_valid) begin
         gap++;
         if (timer_ctl.load || !timer_ctl.run) begin
            gap_valid = 1'b0;                 // Period broken by host
         end else if (tick) begin
            if (gap_valid) begin
               checks++;
               if (gap != 65536 - int'(m_reload)) begin
                  errors++;
                  $display("FAILED %0t: tick period is %0d cycles, expected %0d",
                           $time, gap, 65536 - int'(m_reload));
               end
            end
            gap       = 0;
            gap_valid = 1'b1;
         end
      end

      if (reset) begin
         m_count     = '0;
         m_reload    = '0;
         m_phase     = 10'd1;
         m_pos       = '0;
         m_evt       = '0;
         m_snap      = '0;
         gap_valid   = 1'b0;
         model_valid = 1'b1;
      end else begin
         // Timer, host load first, then self reload, then count
         if (timer_ctl.load) begin
            m_count  = timer_ctl.reload;
            m_reload = timer_ctl.reload;
         end else if (exp_tick) begin
            m_count = m_reload;
         end else if (timer_ctl.run) begin
            m_count = m_count + 16'd1;
         end
         if (exp_tick) begin
            m_phase = {m_phase[8:0], m_phase[9]};   // Rotate, wraps after ten
         end
         // Position, preset over step
         if (pos_ctl.preset) begin
            m_pos = pos_ctl.value;
         end else if (pos_ctl.step) begin
            m_pos = pos_ctl.down ? m_pos - 8'd1 : m_pos + 8'd1;
         end
         // Snapshot takes the old count
         if (evt_ctl.snap) begin
            m_snap = m_evt;
         end
         if (evt_ctl.clear) begin
            m_evt = '0;
         end else if (evt_ctl.event_in) begin
            m_evt = m_evt + 8'd1;
         end
      end
   end

endmodule

`default_nettype wire

/* bench/tb_counter_board.sv */
// Counter board testbench; fixed seed, inputs change 10 ns after each rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_counter_board;

   localparam int HALF_PERIOD   = 50;    // 100 ns clock
   localparam int DRIVE_DELAY   = 10;
   localparam int RESET_CYCLES  = 16;
   localparam int WARMUP_CYCLES = 184;   // Reload 65520, tick every 16
   localparam int RANDOM_CYCLES = 1200;
   localparam int FAST_CYCLES   = 600;   // Reload 65530, ten decade wraps
   localparam int TIMEOUT_CYCLES =
      2 * (RESET_CYCLES + WARMUP_CYCLES + RANDOM_CYCLES + FAST_CYCLES);

   logic                clk;
   logic                reset;
   ctr_pkg::timer_ctl_t timer_ctl;
   ctr_pkg::pos_ctl_t   pos_ctl;
   ctr_pkg::evt_ctl_t   evt_ctl;
   ctr_pkg::word16_t    timer_count;
   logic                tick;
   ctr_pkg::phase_t     phase;
   logic                decade_carry;
   ctr_pkg::byte_t      position;
   logic                position_tc;
   ctr_pkg::byte_t      event_snapshot;
   logic                event_rco;
   int                  error_count;
   int                  check_count;
   int                  cycle_count;

   counter_board UUT (
      .clk            (clk),
      .reset          (reset),
      .timer_ctl      (timer_ctl),
      .pos_ctl        (pos_ctl),
      .evt_ctl        (evt_ctl),
      .timer_count    (timer_count),
      .tick           (tick),
      .phase          (phase),
      .decade_carry   (decade_carry),
      .position       (position),
      .position_tc    (position_tc),
      .event_snapshot (event_snapshot),
      .event_rco      (event_rco)
   );

   board_checker u_checker (
      .clk (clk), .reset (reset),
      .timer_ctl (timer_ctl), .pos_ctl (pos_ctl), .evt_ctl (evt_ctl),
      .timer_count (timer_count), .tick (tick), .phase (phase),
      .decade_carry (decade_carry), .position (position), .position_tc (position_tc),
      .event_snapshot (event_snapshot), .event_rco (event_rco),
      .error_count (error_count), .check_count (check_count)
   );

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////

   task automatic next_drive_slot;
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic drive_idle;
      timer_ctl = '0;
      pos_ctl   = '0;
      evt_ctl   = '0;
   endtask

   // Slice boundaries show up often, the rest is random
   function automatic ctr_pkg::byte_t pick_preset();
      case ($urandom % 8)
         0: return 8'h00;
         1: return 8'h0F;
         2: return 8'hF0;
         3: return 8'hFF;
         default: return ctr_pkg::byte_t'($urandom);
      endcase
   endfunction

   task automatic randomize_counters;
      pos_ctl.preset = ($urandom % 16) == 0;
      pos_ctl.step   = ($urandom % 4) != 0;
      if (($urandom % 32) == 0) begin
         pos_ctl.down = !pos_ctl.down;         // Long runs in one direction
      end
      pos_ctl.value    = pick_preset();
      evt_ctl.event_in = ($urandom % 4) != 0;
      evt_ctl.clear    = ($urandom % 512) == 0;  // Rare, so the count reaches 255
      evt_ctl.snap     = ($urandom % 8) == 0;
   endtask

   task automatic randomize_timer;
      timer_ctl.run    = ($urandom % 64) != 0;
      timer_ctl.load   = ($urandom % 128) == 0;
      timer_ctl.reload = 16'hFFC0 | ctr_pkg::word16_t'($urandom % 64);  // Short periods
   endtask

   task automatic load_timer(input ctr_pkg::word16_t value);
      timer_ctl.load   = 1'b1;
      timer_ctl.run    = 1'b1;
      timer_ctl.reload = value;
      randomize_counters();
      next_drive_slot();
      timer_ctl.load = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      void'($urandom(32'h16ca));
      reset = 1'b1;
      drive_idle();
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;

      load_timer(16'd65520);               // Frequent ticks
      repeat (WARMUP_CYCLES - 1) begin
         randomize_counters();
         next_drive_slot();
      end

      repeat (RANDOM_CYCLES) begin
         randomize_timer();
         randomize_counters();
         next_drive_slot();
      end

      load_timer(16'd65530);               // Many decade wraps
      repeat (FAST_CYCLES - 1) begin
         randomize_counters();
         next_drive_slot();
      end

      drive_idle();
      repeat (2) next_drive_slot();
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // Watchdog on the cycle count
   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
rtl/ctr_pkg.sv
rtl/counter_161.sv
rtl/interval_timer.sv
rtl/counter_191.sv
rtl/updown_counter.sv
rtl/event_counter.sv
rtl/decade_sequencer.sv
rtl/counter_board.sv
bench/board_checker.sv
bench/tb_counter_board.sv

/* Makefile */
# Verilator build and run for the counter board testbench

VERILATOR  ?= verilator
TOP        := tb_counter_board
FILELIST   := list.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing
PASS_MSG   := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Output goes to the console; the exit status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
